/* logic/video_cfg.svh */
`ifndef VIDEO_CFG_SVH
`define VIDEO_CFG_SVH

// ------------------------------
// Frame geometry
// ------------------------------
`define HDISPLAY      640           // Active pixels per line
`define VDISPLAY      480           // Active lines per frame

// Pixel FIFO
`define BUFF_DEPTH    1024          // Power of two
`define FIFO_SLACK    4             // Free slots left when almost full rises

// ------------------------------
// Sprite and pattern colors
// ------------------------------
`define SPRITE_SIZE   8             // Square side in pixels
`define SPRITE_COLOR  24'hFF4000    // Orange
`define SOLID_GRAY    24'h808080    // Mid gray in every channel

`endif

/* logic/videoPkg.sv */
`default_nettype none

package videoPkg;

    // ------------------------------
    // Test pattern selection
    // ------------------------------
    typedef enum logic [1:0] {
        patColorBar = 2'd0,     // Eight vertical bars
        patGradient = 2'd1,     // Red from x, green from y
        patChecker  = 2'd2,     // 8 pixel squares
        patSolid    = 2'd3      // Flat gray
    } patternE;

    // ------------------------------
    // Sprite merge operation
    // ------------------------------
    // Applies only where the sprite covers the pixel
    typedef enum logic [1:0] {
        opPass    = 2'd0,       // Sprite hidden
        opOverlay = 2'd1,       // Sprite color replaces pattern
        opXor     = 2'd2,       // Pattern xor sprite color
        opInvert  = 2'd3        // Pattern inverted
    } rgbOpE;

endpackage

`default_nettype wire

/* logic/dotGenerator.sv */
`default_nettype none
`include "video_cfg.svh"

module dotGenerator
    import videoPkg::*;
#(
    parameter int hDisplay = `HDISPLAY,
    parameter int vDisplay = `VDISPLAY
)(
    input  logic        sysClk,
    input  logic        rstN,
    input  logic        hold,       // FIFO almost full
    input  patternE     pattern,    // Static while out of reset
    output logic [15:0] xPos,
    output logic [15:0] yPos,
    output logic        step,       // Current coordinate consumed
    output logic        frameEnd,   // Step of the last pixel
    output logic [23:0] dotPixel,
    output logic        dotValid
);

    // Bar width in pixels, no divider in the loop
    localparam int barWidth = (hDisplay >= 8) ? hDisplay / 8 : 1;

    logic        runQ;              // Low for one cycle after reset
    logic [15:0] barCnt;            // Pixel within current bar
    logic [2:0]  barIdx;
    logic        lastX;
    logic        lastY;
    logic [23:0] barColor;
    logic [23:0] patPixel;

    assign lastX    = (xPos == 16'(hDisplay - 1));
    assign lastY    = (yPos == 16'(vDisplay - 1));
    assign step     = runQ & ~hold;
    assign frameEnd = step & lastX & lastY;

    // ------------------------------
    // Raster and bar counters
    // ------------------------------
    always_ff @(posedge sysClk)
    begin
        if (!rstN)
        begin
            runQ   <= 1'b0;
            xPos   <= '0;
            yPos   <= '0;
            barCnt <= '0;
            barIdx <= '0;
        end
        else
        begin
            runQ <= 1'b1;
            if (step)
            begin
                if (lastX)
                begin
                    xPos   <= '0;
                    barCnt <= '0;
                    barIdx <= '0;
                    yPos   <= lastY ? 16'd0 : yPos + 16'd1;  // Wrap at frame end
                end
                else
                begin
                    xPos <= xPos + 16'd1;
                    if (barCnt == 16'(barWidth - 1))
                    begin
                        barCnt <= '0;
                        barIdx <= barIdx + 3'd1;    // Next bar
                    end
                    else
                        barCnt <= barCnt + 16'd1;
                end
            end
        end
    end

    // ------------------------------
    // Pattern select
    // ------------------------------
    always_comb
    begin
        case (barIdx)
            3'd0:    barColor = 24'hFFFFFF;     // White
            3'd1:    barColor = 24'hFFFF00;     // Yellow
            3'd2:    barColor = 24'h00FFFF;     // Cyan
            3'd3:    barColor = 24'h00FF00;     // Green
            3'd4:    barColor = 24'hFF00FF;     // Magenta
            3'd5:    barColor = 24'hFF0000;     // Red
            3'd6:    barColor = 24'h0000FF;     // Blue
            default: barColor = 24'h000000;     // Black
        endcase
    end

    always_comb
    begin
        case (pattern)
            patColorBar: patPixel = barColor;
            patGradient: patPixel = {xPos[7:0], yPos[7:0], 8'h00};
            patChecker:  patPixel = (xPos[3] ^ yPos[3]) ? 24'hFFFFFF : 24'h000000;
            default:     patPixel = `SOLID_GRAY;
        endcase
    end

    // Output stage, one cycle after step
    always_ff @(posedge sysClk)
    begin
        if (!rstN)
            dotValid <= 1'b0;
        else
            dotValid <= step;
    end

    always_ff @(posedge sysClk)
    begin
        if (step)
            dotPixel <= patPixel;
    end

    // Raster inside the frame, bar counter matches x
    rasterInFrame: assert property (@(posedge sysClk) disable iff (!rstN)
        (xPos < 16'(hDisplay)) && (yPos < 16'(vDisplay))
        && (barIdx == 3'(xPos / 16'(barWidth))))
        else $error("dotGenerator raster or bar index out of step");

endmodule

`default_nettype wire

/* logic/positionGenerator.sv */
`default_nettype none
`include "video_cfg.svh"

module positionGenerator #(
    parameter int hDisplay = `HDISPLAY,
    parameter int vDisplay = `VDISPLAY
)(
    input  logic        sysClk,
    input  logic        rstN,
    input  logic [15:0] xPos,
    input  logic [15:0] yPos,
    input  logic        step,
    input  logic        frameEnd,
    output logic        spriteHit,
    output logic [23:0] spriteColor
);

    logic [15:0] sprX;              // Sprite origin
    logic [15:0] sprY;
    logic        dirX;              // 1 moves toward larger coordinate
    logic        dirY;
    logic [16:0] nextX;             // {dir, origin} after this frame
    logic [16:0] nextY;
    logic        inX;
    logic        inY;

    // One axis of the bounce, reversal replaces the move
    function automatic logic [16:0] bounce(input logic [15:0] pos, input logic dir,
                                           input int limit);
        logic [16:0] res;
        if (dir)
        begin
            if (int'(pos) + `SPRITE_SIZE >= limit)
                res = {1'b0, pos};          // Far edge would leave display
            else
                res = {1'b1, pos + 16'd1};
        end
        else
        begin
            if (pos == 16'd0)
                res = {1'b1, pos};          // Origin would go negative
            else
                res = {1'b0, pos - 16'd1};
        end
        return res;
    endfunction

    assign nextX = bounce(sprX, dirX, hDisplay);
    assign nextY = bounce(sprY, dirY, vDisplay);

    assign inX = (xPos >= sprX) && (int'(xPos) < int'(sprX) + `SPRITE_SIZE);
    assign inY = (yPos >= sprY) && (int'(yPos) < int'(sprY) + `SPRITE_SIZE);

    // ------------------------------
    // Position update per frame
    // ------------------------------
    always_ff @(posedge sysClk)
    begin
        if (!rstN)
        begin
            sprX <= '0;
            sprY <= '0;
            dirX <= 1'b1;
            dirY <= 1'b1;
        end
        else if (frameEnd)
        begin
            {dirX, sprX} <= nextX;  // Next frame sees new origin
            {dirY, sprY} <= nextY;
        end
    end

    // Hit test, aligned with dotPixel
    always_ff @(posedge sysClk)
    begin
        if (step)
        begin
            spriteHit   <= inX & inY;
            spriteColor <= (inX & inY) ? `SPRITE_COLOR : 24'h000000;
        end
    end

    originInDisplay: assert property (@(posedge sysClk) disable iff (!rstN)
        (int'(sprX) + `SPRITE_SIZE <= hDisplay) && (int'(sprY) + `SPRITE_SIZE <= vDisplay))
        else $error("Sprite left the display");

endmodule

`default_nettype wire

/* logic/rgbOperation.sv */
`default_nettype none

module rgbOperation
    import videoPkg::*;
(
    input  logic        sysClk,
    input  logic        rstN,
    input  rgbOpE       rgbOp,          // Static while out of reset
    input  logic [23:0] dotPixel,
    input  logic        dotValid,
    input  logic        spriteHit,
    input  logic [23:0] spriteColor,
    output logic [23:0] pixel,          // R G B, red in high byte
    output logic        pixValid        // FIFO write enable
);

    logic [23:0] merged;

    // ------------------------------
    // Merge pattern and sprite
    // ------------------------------
    always_comb
    begin
        merged = dotPixel;          // Outside sprite the pattern passes
        if (spriteHit)
        begin
            case (rgbOp)
                opPass:    merged = dotPixel;
                opOverlay: merged = spriteColor;
                opXor:     merged = dotPixel ^ spriteColor;
                default:   merged = ~dotPixel;     // Invert
            endcase
        end
    end

    always_ff @(posedge sysClk)
    begin
        if (!rstN)
            pixValid <= 1'b0;
        else
            pixValid <= dotValid;
    end

    always_ff @(posedge sysClk)
    begin
        if (dotValid)
            pixel <= merged;
    end

    // Operation select held static out of reset
    rgbOpStatic: assert property (@(posedge sysClk) disable iff (!rstN)
        $stable(rgbOp))
        else $error("rgbOp changed while out of reset");

endmodule

`default_nettype wire

/* logic/pixelAsyncFifo.sv */
`default_nettype none
`include "video_cfg.svh"

module pixelAsyncFifo #(
    parameter int buffDepth = `BUFF_DEPTH
)(
    input  logic        sysClk,
    input  logic        pixelClk,
    input  logic        rstN,
    input  logic [23:0] wrData,
    input  logic        wrEn,
    output logic        almostFull,     // sysClk domain
    input  logic        rdEn,           // Video enable level
    output logic [23:0] rdData,         // Holds between reads
    output logic        underrun        // Sticky until reset
);

    localparam int addrW = $clog2(buffDepth);
    localparam int ptrW  = addrW + 1;   // Extra wrap bit

    logic [23:0] mem [buffDepth];

    // Write side
    logic [ptrW-1:0] wrBin;
    logic [ptrW-1:0] wrBinNext;
    logic [ptrW-1:0] wrGray;
    logic [ptrW-1:0] rdGraySync1;
    logic [ptrW-1:0] rdGraySync2;
    logic [ptrW-1:0] rdBinW;
    logic [ptrW-1:0] used;
    logic            full;
    logic            wrGo;

    // Read side
    logic [1:0]      rstSync;
    logic            rdRstN;
    logic [ptrW-1:0] rdBin;
    logic [ptrW-1:0] rdBinNext;
    logic [ptrW-1:0] rdGray;
    logic [ptrW-1:0] wrGraySync1;
    logic [ptrW-1:0] wrGraySync2;
    logic            empty;
    logic            rdGo;

    function automatic logic [ptrW-1:0] gray2bin(input logic [ptrW-1:0] g);
        logic [ptrW-1:0] b;
        b[ptrW-1] = g[ptrW-1];
        for (int i = ptrW - 2; i >= 0; i--)
            b[i] = b[i+1] ^ g[i];
        return b;
    endfunction

    // ------------------------------
    // Write domain
    // ------------------------------
    assign wrBinNext  = wrBin + 1'b1;
    assign full       = (wrGray == {~rdGraySync2[ptrW-1:ptrW-2], rdGraySync2[ptrW-3:0]});
    assign wrGo       = wrEn & ~full;
    assign rdBinW     = gray2bin(rdGraySync2);
    assign used       = wrBin - rdBinW;     // Stale read pointer overcounts
    assign almostFull = (used >= ptrW'(buffDepth - `FIFO_SLACK));

    always_ff @(posedge sysClk)
    begin
        if (!rstN)
        begin
            wrBin       <= '0;
            wrGray      <= '0;
            rdGraySync1 <= '0;
            rdGraySync2 <= '0;
        end
        else
        begin
            rdGraySync1 <= rdGray;
            rdGraySync2 <= rdGraySync1;
            if (wrGo)
            begin
                wrBin  <= wrBinNext;
                wrGray <= (wrBinNext >> 1) ^ wrBinNext;
            end
        end
    end

    always_ff @(posedge sysClk)
    begin
        if (wrGo)
            mem[wrBin[addrW-1:0]] <= wrData;
    end

    // ------------------------------
    // Read domain
    // ------------------------------
    always_ff @(posedge pixelClk)
    begin
        rstSync <= {rstSync[0], rstN};  // Two flop reset sync
    end

    assign rdRstN    = rstSync[1];
    assign rdBinNext = rdBin + 1'b1;
    assign empty     = (rdGray == wrGraySync2);
    assign rdGo      = rdEn & ~empty;

    always_ff @(posedge pixelClk)
    begin
        if (!rdRstN)
        begin
            rdBin       <= '0;
            rdGray      <= '0;
            wrGraySync1 <= '0;
            wrGraySync2 <= '0;
            underrun    <= 1'b0;
        end
        else
        begin
            wrGraySync1 <= wrGray;
            wrGraySync2 <= wrGraySync1;
            if (rdGo)
            begin
                rdBin  <= rdBinNext;
                rdGray <= (rdBinNext >> 1) ^ rdBinNext;
            end
            if (rdEn & empty)
                underrun <= 1'b1;   // Display asked with nothing queued
        end
    end

    always_ff @(posedge pixelClk)
    begin
        if (rdGo)
            rdData <= mem[rdBin[addrW-1:0]];
    end

    // Upstream back-pressure must keep the FIFO from filling
    noWriteWhenFull: assert property (@(posedge sysClk) disable iff (!rstN)
        wrEn |-> !full)
        else $error("pixelAsyncFifo written while full");

    // Read pointer never passes the synchronized write pointer
    noReadWhenEmpty: assert property (@(posedge pixelClk) disable iff (!rdRstN)
        ptrW'(gray2bin(wrGraySync2) - rdBin) <= ptrW'(buffDepth))
        else $error("pixelAsyncFifo read pointer passed write pointer");

endmodule

`default_nettype wire

/* logic/pixelProcessor.sv */
`default_nettype none
`include "video_cfg.svh"

module pixelProcessor
    import videoPkg::*;
#(
    parameter int hDisplay  = `HDISPLAY,
    parameter int vDisplay  = `VDISPLAY,
    parameter int buffDepth = `BUFF_DEPTH
)(
    input  logic        sysClk,
    input  logic        pixelClk,
    input  logic        rstN,
    input  patternE     pattern,
    input  rgbOpE       rgbOp,
    input  logic        fvde,       // Display pulls a pixel
    output logic [23:0] vRgb,
    output logic        underrun
);

    // Raster
    logic [15:0] xPos;
    logic [15:0] yPos;
    logic        step;
    logic        frameEnd;

    // Pipeline stage one
    logic [23:0] dotPixel;
    logic        dotValid;
    logic        spriteHit;
    logic [23:0] spriteColor;

    // Pipeline stage two
    logic [23:0] pixel;
    logic        pixValid;
    logic        almostFull;        // Holds the raster

    // ------------------------------
    // System clock blocks
    // ------------------------------
    dotGenerator #(
        .hDisplay (hDisplay),
        .vDisplay (vDisplay)
    ) dotGen (
        .sysClk   (sysClk),
        .rstN     (rstN),
        .hold     (almostFull),
        .pattern  (pattern),
        .xPos     (xPos),
        .yPos     (yPos),
        .step     (step),
        .frameEnd (frameEnd),
        .dotPixel (dotPixel),
        .dotValid (dotValid)
    );

    positionGenerator #(
        .hDisplay (hDisplay),
        .vDisplay (vDisplay)
    ) posGen (
        .sysClk      (sysClk),
        .rstN        (rstN),
        .xPos        (xPos),
        .yPos        (yPos),
        .step        (step),
        .frameEnd    (frameEnd),
        .spriteHit   (spriteHit),
        .spriteColor (spriteColor)
    );

    rgbOperation rgbOpBlk (
        .sysClk      (sysClk),
        .rstN        (rstN),
        .rgbOp       (rgbOp),
        .dotPixel    (dotPixel),
        .dotValid    (dotValid),
        .spriteHit   (spriteHit),
        .spriteColor (spriteColor),
        .pixel       (pixel),
        .pixValid    (pixValid)
    );

    // ------------------------------
    // Crossing into pixel clock
    // ------------------------------
    pixelAsyncFifo #(
        .buffDepth (buffDepth)
    ) pixFifo (
        .sysClk     (sysClk),
        .pixelClk   (pixelClk),
        .rstN       (rstN),
        .wrData     (pixel),
        .wrEn       (pixValid),
        .almostFull (almostFull),
        .rdEn       (fvde),
        .rdData     (vRgb),
        .underrun   (underrun)
    );

endmodule

`default_nettype wire

/* test/tbPixelProcessor.sv */
`default_nettype none
`include "video_cfg.svh"

module tbPixelProcessor
    import videoPkg::*;
;

    localparam int hDisp       = 16;
    localparam int vDisp       = 8;
    localparam int framePixels = hDisp * vDisp;
    localparam int phaseReads  = 3 * framePixels;     // Three frames per phase
    localparam int modelFrames = 4;                    // Generator runs ahead of reads
    localparam int cycleLimit  = 20000;                // 5 phases x 384 reads x ~10 cycles

    logic        sysClk = 1'b0;
    logic        pixelClk = 1'b0;
    logic        rstN;
    patternE     pattern;
    rgbOpE       rgbOp;
    logic        fvde;
    logic [23:0] vRgb;
    logic        underrun;

    logic [23:0] expPix [modelFrames * framePixels];
    int          rdPtr;                 // Next model entry to compare
    logic        readPending;           // FIFO popped on last pixelClk edge
    int          readMode;              // 0 idle, 1 random, 2 always on
    int          errCount;
    int          checkCount;
    int          cycleCount;

    // Small FIFO so back-pressure shows up within a frame
    pixelProcessor #(
        .hDisplay  (hDisp),
        .vDisplay  (vDisp),
        .buffDepth (16)
    ) i_dut (
        .sysClk   (sysClk),
        .pixelClk (pixelClk),
        .rstN     (rstN),
        .pattern  (pattern),
        .rgbOp    (rgbOp),
        .fvde     (fvde),
        .vRgb     (vRgb),
        .underrun (underrun)
    );

    always #10 sysClk = ~sysClk;
    always #15 pixelClk = ~pixelClk;

    task automatic logFailure(input string msg);
        errCount++;
        $display("[FAIL] %0t: %s", $time, msg);
    endtask

    // ------------------------------
    // Reference model
    // ------------------------------
    function automatic logic [23:0] barColor(input int idx);
        case (idx)
            0:       return 24'hFFFFFF;
            1:       return 24'hFFFF00;
            2:       return 24'h00FFFF;
            3:       return 24'h00FF00;
            4:       return 24'hFF00FF;
            5:       return 24'hFF0000;
            6:       return 24'h0000FF;
            default: return 24'h000000;
        endcase
    endfunction

    // Reverse instead of moving when the square would leave the display
    task automatic bounceAxis(inout int pos, inout int dir, input int limit);
        if ((pos + dir < 0) || (pos + dir + `SPRITE_SIZE > limit))
            dir = -dir;
        else
            pos = pos + dir;
    endtask

    task automatic buildExpected(input patternE pat, input rgbOpE op);
        int          sx;
        int          sy;
        int          dx;
        int          dy;
        int          n;
        logic        hit;
        logic [23:0] pix;
        sx = 0;
        sy = 0;
        dx = 1;
        dy = 1;
        n  = 0;
        for (int f = 0; f < modelFrames; f++)
        begin
            for (int y = 0; y < vDisp; y++)
            begin
                for (int x = 0; x < hDisp; x++)
                begin
                    case (pat)
                        patColorBar: pix = barColor(x / (hDisp / 8));
                        patGradient: pix = {8'(x), 8'(y), 8'h00};
                        patChecker:  pix = ((x / 8) % 2 != (y / 8) % 2) ? 24'hFFFFFF : 24'h0;
                        default:     pix = `SOLID_GRAY;
                    endcase
                    hit = (x >= sx) && (x < sx + `SPRITE_SIZE)
                        && (y >= sy) && (y < sy + `SPRITE_SIZE);
                    if (hit && op == opOverlay)
                        pix = `SPRITE_COLOR;
                    else if (hit && op == opXor)
                        pix = pix ^ `SPRITE_COLOR;
                    else if (hit && op == opInvert)
                        pix = ~pix;
                    expPix[n] = pix;
                    n++;
                end
            end
            bounceAxis(sx, dx, hDisp);     // Next frame position
            bounceAxis(sy, dy, vDisp);
        end
    endtask

    // ------------------------------
    // Read side driver and checker
    // ------------------------------
    initial
    begin
        fvde = 1'b0;
        void'($urandom(32'h9e9));
        forever
        begin
            @(posedge pixelClk);
            #2;
            if (readMode == 2)
                fvde = 1'b1;
            else if (readMode == 1)
                fvde = $urandom() % 2;
            else
                fvde = 1'b0;
        end
    end

    always @(posedge pixelClk)
    begin
        if (!rstN)
        begin
            rdPtr       = 0;            // Sequence restarts at frame 0
            readPending = 1'b0;
        end
        else
        begin
            if (readPending)
            begin
                checkCount++;
                pixelMatchesModel: assert (vRgb === expPix[rdPtr])
                    else logFailure($sformatf("frame %0d (%0d,%0d) got %06h expected %06h",
                        rdPtr / framePixels, rdPtr % hDisp, (rdPtr % framePixels) / hDisp,
                        vRgb, expPix[rdPtr]));
                rdPtr++;
            end
            readPending = i_dut.pixFifo.rdGo;
        end
    end

    always @(posedge sysClk)
    begin
        cycleCount++;
        if (cycleCount >= cycleLimit)
        begin
            $display("Timeout after %0d sysClk cycles, pixel stream stalled", cycleLimit);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // ------------------------------
    // Phases
    // ------------------------------
    // Mode 0 random reads, 1 early read then back-pressure, 2 reads high across reset
    task automatic runPhase(input patternE pat, input rgbOpE op, input int mode);
        @(posedge sysClk);
        #2;
        rstN     = 1'b0;
        pattern  = pat;
        rgbOp    = op;
        readMode = 0;
        buildExpected(pat, op);
        repeat (5) @(posedge sysClk);
        if (mode != 0)
            readMode = 2;               // Pixel domain already in reset
        repeat (5) @(posedge sysClk);
        if (mode == 2)
        begin
            checkCount++;
            underrunClearedByReset: assert (underrun === 1'b0)
                else logFailure("underrun not cleared by reset");
        end
        #2;
        rstN = 1'b1;
        if (mode != 0)
        begin
            wait (rdPtr >= 1);
            @(posedge sysClk);
            checkCount++;
            underrunOnEarlyRead: assert (underrun === 1'b1)
                else logFailure("underrun low after reading an empty FIFO");
        end
        if (mode == 1)
        begin
            readMode = 0;               // Display stalls until the FIFO backs up
            while (!i_dut.almostFull)
                @(posedge sysClk);
            repeat (50)
            begin
                @(posedge sysClk);
                checkCount++;
                holdStopsRaster: assert (!i_dut.almostFull || !i_dut.step)
                    else logFailure("raster stepped while FIFO almost full");
            end
        end
        if (mode != 2)
            readMode = 1;
        wait (rdPtr >= phaseReads);
    endtask

    initial
    begin
        rstN       = 1'b0;
        pattern    = patColorBar;
        rgbOp      = opPass;
        readMode   = 0;
        errCount   = 0;
        checkCount = 0;
        cycleCount = 0;
        runPhase(patColorBar, opPass, 0);
        runPhase(patGradient, opOverlay, 0);
        runPhase(patChecker, opXor, 0);
        runPhase(patSolid, opInvert, 1);
        runPhase(patColorBar, opOverlay, 2);   // Mid-stream reset
        $display("Checks: %0d  Errors: %0d", checkCount, errCount);
        if (errCount == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+logic
logic/videoPkg.sv
logic/dotGenerator.sv
logic/positionGenerator.sv
logic/rgbOperation.sv
logic/pixelAsyncFifo.sv
logic/pixelProcessor.sv
test/tbPixelProcessor.sv
